// File: logic/dsp_pkg.sv
package dsp_pkg;

	// operand and result widths
	localparam int A_W = 8;
	localparam int B_W = 8;
	localparam int PROD_W = 16;
	localparam int ACC_W = 24;

	// micro-instruction fields
	localparam int A_S_W = 1;
	localparam int B_S_W = 1;
	localparam int SHIFT_MODE_W = 2;
	localparam int ACC_MODE_W = 1;

	// product shift per shifter mode step, so modes 0..3 give 0, 4, 8, 12
	localparam int SHIFT_STEP = 4;

	typedef logic [A_W-1:0] a_word_t;
	typedef logic [B_W-1:0] b_word_t;
	typedef logic [PROD_W-1:0] prod_t;
	typedef logic [ACC_W-1:0] acc_t;
	typedef logic [SHIFT_MODE_W-1:0] shift_mode_t;

	// instruction layout, msb first: a_s, b_s, addr increment, shifter mode, acc_mode
	function automatic int instr_w(input int b_d_log2);
		return A_S_W + B_S_W + b_d_log2 + SHIFT_MODE_W + ACC_MODE_W;
	endfunction

endpackage

// File: logic/mac_sequencer.sv
`timescale 1ns/1ps

module mac_sequencer #(
	parameter int PROG_D = 4,
	parameter int B_D = 4
) (
	input logic clk,
	input logic reset,

	input logic config_en,
	input logic config_in,
	output logic config_out,

	input logic in_valid,
	input logic space_ok,
	output logic in_ready,

	output logic step,

	output logic a_mux,
	output logic res_in_select,
	output logic a_s,
	output logic b_s,
	output dsp_pkg::shift_mode_t shifter_mode,
	output logic acc_mode,
	output logic [$clog2(B_D)-1:0] b_addr
);

	localparam int CNT_W = $clog2(PROG_D);
	localparam int B_D_LOG2 = $clog2(B_D);
	localparam int INSTR_W = dsp_pkg::instr_w(B_D_LOG2);
	localparam int MEM_W = INSTR_W * PROG_D;

	// bit positions inside the scan chain, config_in enters at bit 0
	localparam int LIM_LSB = 2;
	localparam int MEM_LSB = LIM_LSB + CNT_W;
	localparam int BASE_LSB = MEM_LSB + MEM_W;
	localparam int STEP_LSB = BASE_LSB + B_D_LOG2;
	localparam int CHAIN_W = STEP_LSB + B_D_LOG2;

	logic [CHAIN_W-1:0] conf_chain;

	logic [CNT_W-1:0] conf_cnt_limit;
	logic [MEM_W-1:0] conf_mem;
	logic [B_D_LOG2-1:0] conf_base_limit;
	logic [B_D_LOG2-1:0] conf_addr_step;

	logic [CNT_W-1:0] cntr;
	logic [B_D_LOG2-1:0] b_addr_base;
	logic [B_D_LOG2:0] base_sum;
	logic [INSTR_W-1:0] instr;
	logic [B_D_LOG2-1:0] b_addr_inc;
	logic run;

	always_ff @(posedge clk) begin
		if (config_en)
			conf_chain <= {conf_chain[CHAIN_W-2:0], config_in};
	end

	assign config_out = conf_chain[CHAIN_W-1];

	assign a_mux = conf_chain[0];
	assign res_in_select = conf_chain[1];
	assign conf_cnt_limit = conf_chain[LIM_LSB +: CNT_W];
	assign conf_mem = conf_chain[MEM_LSB +: MEM_W];
	assign conf_base_limit = conf_chain[BASE_LSB +: B_D_LOG2];
	assign conf_addr_step = conf_chain[STEP_LSB +: B_D_LOG2];

	// hold off input for one cycle after reset
	always_ff @(posedge clk) begin
		if (reset)
			run <= 1'b0;
		else
			run <= 1'b1;
	end

	assign in_ready = run & space_ok & ~config_en;
	assign step = in_valid & in_ready;

	assign base_sum = {1'b0, b_addr_base} + {1'b0, conf_addr_step};

	always_ff @(posedge clk) begin
		if (reset) begin
			cntr <= '0;
			b_addr_base <= '0;
		end else if (step) begin
			if (cntr == conf_cnt_limit) begin
				cntr <= '0;
				if (base_sum > {1'b0, conf_base_limit}) // past the limit, start over
					b_addr_base <= '0;
				else
					b_addr_base <= base_sum[B_D_LOG2-1:0];
			end else begin
				cntr <= cntr + 1'b1;
			end
		end
	end

	assign instr = conf_mem[cntr*INSTR_W +: INSTR_W];
	assign {a_s, b_s, b_addr_inc, shifter_mode, acc_mode} = instr;

	assign b_addr = b_addr_base + b_addr_inc; // wraps modulo B_D

endmodule

// File: logic/b_operand_bank.sv
`timescale 1ns/1ps

module b_operand_bank #(
	parameter int B_D = 4
) (
	input logic clk,

	input logic b_wr_en,
	input logic [$clog2(B_D)-1:0] b_wr_addr,
	input dsp_pkg::b_word_t b_wr_data,

	input logic [$clog2(B_D)-1:0] b_addr,
	output dsp_pkg::b_word_t b_rd_data
);

	dsp_pkg::b_word_t mem [B_D];

	always_ff @(posedge clk) begin
		if (b_wr_en)
			mem[b_wr_addr] <= b_wr_data;
	end

	// async read, a write shows up the cycle after
	assign b_rd_data = mem[b_addr];

endmodule

// File: logic/mac_datapath.sv
`timescale 1ns/1ps

module mac_datapath (
	input logic clk,
	input logic reset,

	input logic step,
	input dsp_pkg::a_word_t a_in,
	input dsp_pkg::acc_t c_in,
	input dsp_pkg::b_word_t b_rd_data,

	input logic a_mux,
	input logic res_in_select,
	input logic a_s,
	input logic b_s,
	input dsp_pkg::shift_mode_t shifter_mode,
	input logic acc_mode,

	output logic res_valid,
	output dsp_pkg::acc_t res_data,
	output logic [1:0] inflight
);

	localparam int A_W = dsp_pkg::A_W;
	localparam int B_W = dsp_pkg::B_W;
	localparam int PROD_W = dsp_pkg::PROD_W;
	localparam int ACC_W = dsp_pkg::ACC_W;

	dsp_pkg::a_word_t a_prev;
	dsp_pkg::a_word_t a_op;
	logic [A_W:0] a_ext;
	logic [B_W:0] b_ext;
	logic signed [A_W+B_W+1:0] prod_full;

	logic s1_valid;
	dsp_pkg::prod_t s1_prod;
	dsp_pkg::acc_t s1_seed;
	dsp_pkg::shift_mode_t s1_mode;
	logic s1_acc_mode;
	logic s1_signed;

	dsp_pkg::acc_t prod_ext;
	dsp_pkg::acc_t prod_shifted;
	dsp_pkg::acc_t acc;
	dsp_pkg::acc_t acc_next;

	// stage 1: operand select, 9x9 multiply
	assign a_op = a_mux ? a_prev : a_in;
	assign a_ext = {a_s & a_op[A_W-1], a_op};
	assign b_ext = {b_s & b_rd_data[B_W-1], b_rd_data};
	assign prod_full = $signed(a_ext) * $signed(b_ext);

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			a_prev <= '0;
		end else begin
			s1_valid <= step;
			if (step)
				a_prev <= a_in;
		end
	end

	always_ff @(posedge clk) begin
		if (step) begin
			s1_prod <= prod_full[PROD_W-1:0];
			s1_seed <= res_in_select ? c_in : '0;
			s1_mode <= shifter_mode;
			s1_acc_mode <= acc_mode;
			s1_signed <= a_s | b_s; // unsigned x unsigned fits 16 bits, no sign
		end
	end

	// stage 2: shift and accumulate
	assign prod_ext = {{(ACC_W-PROD_W){s1_signed & s1_prod[PROD_W-1]}}, s1_prod};
	assign prod_shifted = prod_ext << (s1_mode * dsp_pkg::SHIFT_STEP);
	assign acc_next = (s1_acc_mode ? acc : s1_seed) + prod_shifted; // wraps at 24 bits

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			acc <= '0;
		end else begin
			res_valid <= s1_valid;
			if (s1_valid)
				acc <= acc_next;
		end
	end

	assign res_data = acc;
	assign inflight = {1'b0, s1_valid} + {1'b0, res_valid};

endmodule

// File: logic/result_fifo.sv
`timescale 1ns/1ps

module result_fifo #(
	parameter int FIFO_D = 4
) (
	input logic clk,
	input logic reset,

	input logic res_valid,
	input dsp_pkg::acc_t res_data,
	input logic [1:0] inflight,
	output logic space_ok,

	output logic out_valid,
	input logic out_ready,
	output dsp_pkg::acc_t out_data
);

	localparam int PTR_W = (FIFO_D > 1) ? $clog2(FIFO_D) : 1;
	localparam int CNT_W = $clog2(FIFO_D + 1);

	dsp_pkg::acc_t mem [FIFO_D];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;

	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign pop = out_valid & out_ready;

	// count what is stored plus what the pipeline still owes us
	assign space_ok = (32'(count) + 32'(inflight)) < FIFO_D;

	always_ff @(posedge clk) begin
		if (res_valid)
			mem[wr_ptr] <= res_data; // space already reserved upstream
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (res_valid)
				wr_ptr <= (32'(wr_ptr) == FIFO_D - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (32'(rd_ptr) == FIFO_D - 1) ? '0 : rd_ptr + 1'b1;
			if (res_valid && !pop)
				count <= count + 1'b1;
			else if (pop && !res_valid)
				count <= count - 1'b1;
		end
	end

endmodule

// File: logic/dsp_tile.sv
`timescale 1ns/1ps

module dsp_tile #(
	parameter int PROG_D = 4,
	parameter int B_D = 4,
	parameter int FIFO_D = 4
) (
	input logic clk,
	input logic reset,

	input logic config_en,
	input logic config_in,
	output logic config_out,

	input logic in_valid,
	output logic in_ready,
	input dsp_pkg::a_word_t a_in,
	input dsp_pkg::acc_t c_in,

	input logic b_wr_en,
	input logic [$clog2(B_D)-1:0] b_wr_addr,
	input dsp_pkg::b_word_t b_wr_data,

	output logic out_valid,
	input logic out_ready,
	output dsp_pkg::acc_t out_data
);

	logic step;
	logic space_ok;
	logic a_mux;
	logic res_in_select;
	logic a_s;
	logic b_s;
	dsp_pkg::shift_mode_t shifter_mode;
	logic acc_mode;
	logic [$clog2(B_D)-1:0] b_addr;
	dsp_pkg::b_word_t b_rd_data;
	logic res_valid;
	dsp_pkg::acc_t res_data;
	logic [1:0] inflight;

	mac_sequencer #(
		.PROG_D(PROG_D),
		.B_D(B_D)
	) mac_sequencer_inst (
		.clk(clk),
		.reset(reset),
		.config_en(config_en),
		.config_in(config_in),
		.config_out(config_out),
		.in_valid(in_valid),
		.space_ok(space_ok),
		.in_ready(in_ready),
		.step(step),
		.a_mux(a_mux),
		.res_in_select(res_in_select),
		.a_s(a_s),
		.b_s(b_s),
		.shifter_mode(shifter_mode),
		.acc_mode(acc_mode),
		.b_addr(b_addr)
	);

	b_operand_bank #(
		.B_D(B_D)
	) b_operand_bank_inst (
		.clk(clk),
		.b_wr_en(b_wr_en),
		.b_wr_addr(b_wr_addr),
		.b_wr_data(b_wr_data),
		.b_addr(b_addr),
		.b_rd_data(b_rd_data)
	);

	mac_datapath mac_datapath_inst (
		.clk(clk),
		.reset(reset),
		.step(step),
		.a_in(a_in),
		.c_in(c_in),
		.b_rd_data(b_rd_data),
		.a_mux(a_mux),
		.res_in_select(res_in_select),
		.a_s(a_s),
		.b_s(b_s),
		.shifter_mode(shifter_mode),
		.acc_mode(acc_mode),
		.res_valid(res_valid),
		.res_data(res_data),
		.inflight(inflight)
	);

	result_fifo #(
		.FIFO_D(FIFO_D)
	) result_fifo_inst (
		.clk(clk),
		.reset(reset),
		.res_valid(res_valid),
		.res_data(res_data),
		.inflight(inflight),
		.space_ok(space_ok),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

endmodule

// File: tb/dsp_tile_tb.sv
`timescale 1ns/1ps

module dsp_tile_tb;

	localparam int CLK_PERIOD = 40;
	localparam int CFG_BITS = 36;
	localparam int N_ROWS = 4;
	localparam int N_STEPS = 12;
	localparam int WATCHDOG_CYCLES = (N_ROWS * CFG_BITS + N_ROWS * N_STEPS) * 8;

	logic clk = 1'b0;
	logic reset;
	logic config_en;
	logic config_in;
	logic config_out;
	logic in_valid;
	logic in_ready;
	dsp_pkg::a_word_t a_in;
	dsp_pkg::acc_t c_in;
	logic b_wr_en;
	logic [1:0] b_wr_addr;
	dsp_pkg::b_word_t b_wr_data;
	logic out_valid;
	logic out_ready;
	dsp_pkg::acc_t out_data;

	// stimulus table, step k takes a byte k of a_tab and c word k%4 of c_tab
	logic [35:0] cfg_tab [N_ROWS];
	logic [31:0] b_tab [N_ROWS];
	logic [95:0] a_tab [N_ROWS];
	logic [95:0] c_tab [N_ROWS];
	logic stall_tab [N_ROWS];

	// reference model state
	logic [35:0] m_cfg;
	dsp_pkg::b_word_t m_bank [4];
	logic [1:0] m_cntr;
	logic [1:0] m_base;
	dsp_pkg::acc_t m_acc;
	dsp_pkg::a_word_t m_aprev;

	dsp_pkg::acc_t exp_q [$];
	logic cfg_hist [$];
	logic hold_ready;
	logic [16:0] prod_lfsr = 17'd84185;
	logic [16:0] cons_lfsr = 17'd84185;
	int errors = 0;
	int n_steps = 0;
	int n_results = 0;
	int r;
	int k;

	dsp_tile #(
		.PROG_D(4),
		.B_D(4),
		.FIFO_D(4)
	) dsp_tile_inst (
		.clk(clk),
		.reset(reset),
		.config_en(config_en),
		.config_in(config_in),
		.config_out(config_out),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.a_in(a_in),
		.c_in(c_in),
		.b_wr_en(b_wr_en),
		.b_wr_addr(b_wr_addr),
		.b_wr_data(b_wr_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]}; // x^17 + x^14 + 1
	endfunction

	task automatic take_bit(inout logic [16:0] s, output logic b);
		s = lfsr_next(s);
		b = s[0];
	endtask

	// {a_s, b_s, increment, shifter mode, acc_mode}
	function automatic logic [6:0] make_instr(input logic a_s, input logic b_s,
			input logic [1:0] inc, input logic [1:0] mode, input logic acc);
		return {a_s, b_s, inc, mode, acc};
	endfunction

	function automatic logic [35:0] make_cfg(input logic [1:0] addr_step,
			input logic [1:0] base_lim, input logic [6:0] i3, input logic [6:0] i2,
			input logic [6:0] i1, input logic [6:0] i0, input logic [1:0] cnt_lim,
			input logic res_sel, input logic amux);
		return {addr_step, base_lim, i3, i2, i1, i0, cnt_lim, res_sel, amux};
	endfunction

	task automatic fill_table();
		// shift modes and acc pattern, base steps 0,1 and wraps at limit 1
		cfg_tab[0] = make_cfg(2'd1, 2'd1, make_instr(0, 0, 3, 3, 1), make_instr(0, 0, 2, 2, 1),
			make_instr(0, 0, 1, 1, 1), make_instr(0, 0, 0, 0, 0), 2'd3, 1'b1, 1'b0);
		b_tab[0] = {8'hC5, 8'h7F, 8'h11, 8'h03};
		a_tab[0] = 96'h0F234567_89ABCDEF_10325476;
		c_tab[0] = 96'h000100_ABCDEF_123456_000010;
		stall_tab[0] = 1'b0;
		// every a_s/b_s pair against 0x80 and 0xFF
		cfg_tab[1] = make_cfg(2'd0, 2'd0, make_instr(0, 0, 3, 0, 0), make_instr(0, 1, 2, 0, 0),
			make_instr(1, 0, 1, 0, 0), make_instr(1, 1, 0, 0, 0), 2'd3, 1'b0, 1'b0);
		b_tab[1] = {8'hFF, 8'h80, 8'hFF, 8'h80};
		a_tab[1] = 96'hFF00017F_FF8080FF_80FFFF80;
		c_tab[1] = 96'h0;
		stall_tab[1] = 1'b0;
		// previous a_in, c_in seed, big shifted products wrap the accumulator
		cfg_tab[2] = make_cfg(2'd2, 2'd3, make_instr(0, 0, 0, 0, 0), make_instr(0, 0, 0, 0, 0),
			make_instr(0, 0, 1, 3, 1), make_instr(1, 1, 0, 3, 0), 2'd1, 1'b1, 1'b1);
		b_tab[2] = {8'h40, 8'hFF, 8'h81, 8'hFF};
		a_tab[2] = 96'hFFFF7FFF_FFFFFF80_FFFFFF11;
		c_tab[2] = 96'hFFF000_800000_7FFFFF_FFFFFF;
		stall_tab[2] = 1'b0;
		// three-instruction loop under back-pressure
		cfg_tab[3] = make_cfg(2'd3, 2'd3, make_instr(0, 0, 0, 0, 0), make_instr(1, 0, 2, 2, 1),
			make_instr(0, 1, 1, 1, 1), make_instr(0, 0, 0, 0, 0), 2'd2, 1'b0, 1'b0);
		b_tab[3] = {8'h99, 8'hE0, 8'h07, 8'h5A};
		a_tab[3] = 96'h01020304_05060708_090A0B0C;
		c_tab[3] = 96'h0;
		stall_tab[3] = 1'b1;
	endtask

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) tick();
		reset = 1'b0;
		assert (!out_valid && !in_ready) else begin
			$display("out_valid or in_ready is high right after reset");
			errors++;
		end
		m_cntr = '0;
		m_base = '0;
		m_acc = '0;
		m_aprev = '0;
	endtask

	// msb first, so bit 0 of the word sits next to config_in when done
	task automatic load_config(input logic [35:0] w);
		config_en = 1'b1;
		for (int i = CFG_BITS - 1; i >= 0; i--) begin
			if (cfg_hist.size() >= CFG_BITS)
				assert (config_out == cfg_hist[cfg_hist.size() - CFG_BITS]) else begin
					$display("Mismatch config_out got 0x%0h expected 0x%0h", config_out,
						cfg_hist[cfg_hist.size() - CFG_BITS]);
					errors++;
				end
			config_in = w[i];
			cfg_hist.push_back(w[i]);
			tick();
		end
		config_en = 1'b0;
		m_cfg = w;
	endtask

	task automatic write_bank(input logic [31:0] words);
		for (int i = 0; i < 4; i++) begin
			b_wr_en = 1'b1;
			b_wr_addr = i[1:0];
			b_wr_data = words[8*i +: 8];
			m_bank[i] = words[8*i +: 8];
			tick();
		end
		b_wr_en = 1'b0;
	endtask

	task automatic model_step(input dsp_pkg::a_word_t a, input dsp_pkg::acc_t c);
		logic [6:0] ins;
		dsp_pkg::a_word_t a_op;
		dsp_pkg::b_word_t b_op;
		logic [1:0] addr;
		logic [2:0] sum;
		int av;
		int bv;
		logic [31:0] wide;
		dsp_pkg::acc_t seed;
		ins = m_cfg[4 + 7*m_cntr +: 7];
		a_op = m_cfg[0] ? m_aprev : a;
		m_aprev = a;
		addr = m_base + ins[4:3]; // modulo bank depth
		b_op = m_bank[addr];
		if (ins[6])
			av = $signed(a_op);
		else
			av = a_op;
		if (ins[5])
			bv = $signed(b_op);
		else
			bv = b_op;
		wide = (av * bv) << (4 * ins[2:1]);
		if (ins[0])
			seed = m_acc;
		else
			seed = m_cfg[1] ? c : '0;
		m_acc = seed + wide[23:0];
		exp_q.push_back(m_acc);
		n_steps++;
		if (m_cntr == m_cfg[3:2]) begin
			m_cntr = '0;
			sum = {1'b0, m_base} + {1'b0, m_cfg[35:34]};
			m_base = (sum > {1'b0, m_cfg[33:32]}) ? 2'd0 : sum[1:0];
		end else begin
			m_cntr = m_cntr + 1'b1;
		end
	endtask

	task automatic send_step(input dsp_pkg::a_word_t a, input dsp_pkg::acc_t c);
		logic g1;
		logic g2;
		logic accepted;
		take_bit(prod_lfsr, g1);
		take_bit(prod_lfsr, g2);
		if (g1 && g2)
			tick(); // idle cycle on the input
		in_valid = 1'b1;
		a_in = a;
		c_in = c;
		accepted = 1'b0;
		while (!accepted) begin
			accepted = in_ready; // taken at the coming edge
			if (accepted)
				model_step(a, c);
			tick();
		end
		in_valid = 1'b0;
	endtask

	// consumer with random stalls, checks every word it takes
	always begin
		logic s1;
		logic s2;
		@(posedge clk);
		#2;
		take_bit(cons_lfsr, s1);
		take_bit(cons_lfsr, s2);
		out_ready = !hold_ready && !(s1 && s2);
		assert (!(out_valid && exp_q.size() == 0)) else begin
			$display("out_valid is high but no accepted step is waiting for a result");
			errors++;
		end
		if (out_valid && out_ready) begin
			n_results++;
			if (exp_q.size() != 0) begin
				assert (out_data == exp_q[0]) else begin
					$display("Mismatch out_data got 0x%06h expected 0x%06h", out_data,
						exp_q[0]);
					errors++;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
		$display("errors %0d steps %0d results %0d", errors, n_steps, n_results);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		reset = 1'b1;
		config_en = 1'b0;
		config_in = 1'b0;
		in_valid = 1'b0;
		a_in = '0;
		c_in = '0;
		b_wr_en = 1'b0;
		b_wr_addr = '0;
		b_wr_data = '0;
		out_ready = 1'b0;
		hold_ready = 1'b0;
		fill_table();
		for (r = 0; r < N_ROWS; r++) begin
			hold_ready = stall_tab[r];
			apply_reset();
			load_config(cfg_tab[r]);
			write_bank(b_tab[r]);
			fork
				for (k = 0; k < N_STEPS; k++)
					send_step(a_tab[r][8*k +: 8], c_tab[r][24*(k % 4) +: 24]);
				if (stall_tab[r]) begin
					repeat (20) tick();
					assert (!in_ready) else begin
						$display("in_ready stayed high while out_ready was held low");
						errors++;
					end
					hold_ready = 1'b0;
				end
			join
			while (exp_q.size() != 0)
				tick();
			repeat (2) tick();
		end
		assert (n_results == n_steps) else begin
			$display("got %0d results for %0d accepted steps", n_results, n_steps);
			errors++;
		end
		$display("errors %0d steps %0d results %0d", errors, n_steps, n_results);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: filelist.f
logic/dsp_pkg.sv
logic/mac_sequencer.sv
logic/b_operand_bank.sv
logic/mac_datapath.sv
logic/result_fifo.sv
logic/dsp_tile.sv
tb/dsp_tile_tb.sv
